// ==== mem_subsys_top.f ====
common/mem_pkg.sv
fetch/inst_fetch.sv
lsu/load_store_unit.sv
hw/mem_arbiter.sv
hw/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// ==== testbench/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    localparam int MEM_SIZE   = 1024;
    // stores only land at or above this address, fetch stays below
    localparam int STORE_BASE = 512;
    localparam int PC_LIMIT   = 496;
    localparam int N_INST     = 200;
    localparam int N_LS       = 150;
    localparam int MAX_CYCLES = 40 * (N_INST + N_LS);

    logic              clk;
    logic              reset_i;
    logic              redirect_i;
    logic [ADDR_W-1:0] redirect_pc_i;
    logic              inst_ready_i;
    logic              inst_valid_o;
    logic [ADDR_W-1:0] inst_pc_o;
    logic [XLEN-1:0]   inst_o;
    logic              ls_valid_i;
    logic              ls_we_i;
    mem_size_e         ls_size_i;
    logic [ADDR_W-1:0] ls_addr_i;
    logic [XLEN-1:0]   ls_wdata_i;
    logic              ls_ready_o;
    logic              ls_resp_valid_o;
    logic [XLEN-1:0]   ls_resp_rdata_o;
    logic [ADDR_W-1:0] mem_addr_o;
    logic              mem_we_o;
    logic [BYTE_W-1:0] mem_wdata_o;
    logic [BYTE_W-1:0] mem_rdata_i;

    // byte memory behind the DUT and the reference copy
    logic [7:0] mem [0:MEM_SIZE-1];
    logic [7:0] shadow [0:MEM_SIZE-1];

    integer            seed;
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] exp_pc;
    logic [ADDR_W-1:0] last_store_addr;
    logic [XLEN-1:0]   resp_q [$];
    logic              store_q [$];
    logic              hold_q;
    logic [ADDR_W-1:0] hold_pc;
    logic [XLEN-1:0]   hold_inst;
    logic              ls_pending;
    int                inst_count;
    int                ls_issued;
    int                stores_open;
    int                checks;
    int                errors;
    int                cycles;

    mem_subsys_top dut0 (
        .clk             (clk),
        .reset_i         (reset_i),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .inst_ready_i    (inst_ready_i),
        .inst_valid_o    (inst_valid_o),
        .inst_pc_o       (inst_pc_o),
        .inst_o          (inst_o),
        .ls_valid_i      (ls_valid_i),
        .ls_we_i         (ls_we_i),
        .ls_size_i       (ls_size_i),
        .ls_addr_i       (ls_addr_i),
        .ls_wdata_i      (ls_wdata_i),
        .ls_ready_o      (ls_ready_o),
        .ls_resp_valid_o (ls_resp_valid_o),
        .ls_resp_rdata_o (ls_resp_rdata_o),
        .mem_addr_o      (mem_addr_o),
        .mem_we_o        (mem_we_o),
        .mem_wdata_o     (mem_wdata_o),
        .mem_rdata_i     (mem_rdata_i)
    );

    always #10 clk = ~clk;

    // read data comes back one cycle after the address
    always @(posedge clk) begin
        mem_rdata_i <= mem[mem_addr_o % MEM_SIZE];
        if (mem_we_o) begin
            mem[mem_addr_o % MEM_SIZE] <= mem_wdata_o;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d instructions, %0d requests, errors %0d",
                     cycles, inst_count, ls_issued, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    function automatic int size_bytes(mem_size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // little-endian bytes from the reference copy, upper bytes zero
    function automatic logic [XLEN-1:0] shadow_read(logic [ADDR_W-1:0] addr, int nbytes);
        logic [XLEN-1:0] value;
        value = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[i*8 +: 8] = shadow[(addr + ADDR_W'(i)) % MEM_SIZE];
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("error in cycle %0d: %s", cycles, what);
        end
    endtask

    task automatic sample_outputs();
        logic [XLEN-1:0] expected;
        // instruction held under back-pressure
        if (hold_q) begin
            check_true(inst_valid_o, "inst_valid_o dropped before the transfer");
            check_value("inst_pc_o", hold_pc, inst_pc_o);
            check_value("inst_o", hold_inst, inst_o);
        end
        if (mem_we_o === 1'b1) begin
            check_true(stores_open > 0, "memory write with no store outstanding");
            check_true(mem_addr_o >= STORE_BASE && mem_addr_o < MEM_SIZE,
                       "memory write outside the store region");
            // byte written must be the one the store put in the model
            check_value("mem_wdata_o", shadow[mem_addr_o % MEM_SIZE], mem_wdata_o);
        end
        if (ls_resp_valid_o === 1'b1) begin
            if (resp_q.size() == 0) begin
                check_true(1'b0, "load/store response with no request outstanding");
            end else begin
                expected = resp_q.pop_front();
                check_value("ls_resp_rdata_o", expected, ls_resp_rdata_o);
                if (store_q.pop_front()) begin
                    stores_open--;
                end
            end
        end
    endtask

    task automatic drive_fetch();
        rnd = $random(seed);
        redirect_i = 1'b0;
        inst_ready_i = rnd[0];
        // no redirect before the reset path delivered its first word
        if (inst_count > 0 && (exp_pc >= PC_LIMIT || rnd[7:3] == 5'd0)) begin
            redirect_i = 1'b1;
            redirect_pc_i = ADDR_W'(rnd[15:8] % 8'd123) << 2;
            inst_ready_i = 1'b0;
            exp_pc = redirect_pc_i;
        end
        if (inst_valid_o && inst_ready_i) begin
            check_value("inst_pc_o", exp_pc, inst_pc_o);
            check_value("inst_o", shadow_read(exp_pc, 4), inst_o);
            exp_pc = exp_pc + 4;
            inst_count++;
        end
        hold_q = inst_valid_o && !inst_ready_i && !redirect_i;
        hold_pc = inst_pc_o;
        hold_inst = inst_o;
    endtask

    task automatic record_request();
        int nbytes;
        nbytes = size_bytes(ls_size_i);
        ls_issued++;
        if (ls_we_i) begin
            for (int i = 0; i < nbytes; i++) begin
                shadow[(ls_addr_i + ADDR_W'(i)) % MEM_SIZE] = ls_wdata_i[i*8 +: 8];
            end
            resp_q.push_back('0);
            store_q.push_back(1'b1);
            stores_open++;
            last_store_addr = ls_addr_i;
        end else begin
            resp_q.push_back(shadow_read(ls_addr_i, nbytes));
            store_q.push_back(1'b0);
        end
    endtask

    task automatic drive_ls();
        // a request not yet accepted stays on the inputs
        if (!ls_pending) begin
            rnd = $random(seed);
            ls_valid_i = 1'b0;
            if (inst_count >= 4 && ls_issued < N_LS && rnd[1:0] != 2'd0) begin
                ls_valid_i = 1'b1;
                ls_we_i = rnd[2];
                ls_size_i = mem_size_e'(2'(rnd[5:3] % 3'd3));
                if (rnd[2]) begin
                    ls_addr_i = ADDR_W'(STORE_BASE) + ADDR_W'(rnd[17:8] % 10'd509);
                end else if (rnd[6]) begin
                    // whole word over the last store, neighbours included
                    ls_addr_i = last_store_addr;
                    ls_size_i = SIZE_WORD;
                end else begin
                    ls_addr_i = ADDR_W'(rnd[17:8] % 10'd1021);
                end
                ls_wdata_i = $random(seed);
            end
        end
        ls_pending = ls_valid_i && !ls_ready_o;
        if (ls_valid_i && ls_ready_o) begin
            record_request();
        end
    endtask

    task automatic run_cycle();
        @(negedge clk);
        sample_outputs();
        drive_fetch();
        drive_ls();
    endtask

    initial begin
        seed = 32'h2e0d;
        clk = 1'b0;
        reset_i = 1'b1;
        redirect_i = 1'b0;
        redirect_pc_i = '0;
        inst_ready_i = 1'b0;
        ls_valid_i = 1'b0;
        ls_we_i = 1'b0;
        ls_size_i = SIZE_BYTE;
        ls_addr_i = '0;
        ls_wdata_i = '0;
        mem_rdata_i = '0;
        exp_pc = RESET_PC;
        last_store_addr = ADDR_W'(STORE_BASE);
        hold_q = 1'b0;
        hold_pc = '0;
        hold_inst = '0;
        ls_pending = 1'b0;
        inst_count = 0;
        ls_issued = 0;
        stores_open = 0;
        checks = 0;
        errors = 0;
        cycles = 0;
        for (int i = 0; i < MEM_SIZE; i++) begin
            rnd = $random(seed);
            mem[i] = rnd[7:0];
            shadow[i] = rnd[7:0];
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_true(inst_valid_o === 1'b0, "inst_valid_o high in reset");
        check_true(ls_resp_valid_o === 1'b0, "ls_resp_valid_o high in reset");
        check_true(mem_we_o === 1'b0, "mem_we_o high in reset");
        check_value("inst_pc_o", RESET_PC, inst_pc_o);
        reset_i = 1'b0;

        while (inst_count < N_INST || ls_issued < N_LS) begin
            run_cycle();
        end
        // outstanding responses, then a few quiet cycles for strays
        while (resp_q.size() != 0) begin
            run_cycle();
        end
        repeat (8) run_cycle();

        $display("checks %0d, errors %0d, instructions %0d, load/store requests %0d",
                 checks, errors, inst_count, ls_issued);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top import mem_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset_i,

    // redirect
    input  wire logic              redirect_i,
    input  wire logic [ADDR_W-1:0] redirect_pc_i,

    // instruction stream
    input  wire logic              inst_ready_i,
    output logic                   inst_valid_o,
    output logic      [ADDR_W-1:0] inst_pc_o,
    output logic      [XLEN-1:0]   inst_o,

    // load/store request and response
    input  wire logic              ls_valid_i,
    input  wire logic              ls_we_i,
    input  wire mem_size_e         ls_size_i,
    input  wire logic [ADDR_W-1:0] ls_addr_i,
    input  wire logic [XLEN-1:0]   ls_wdata_i,
    output logic                   ls_ready_o,
    output logic                   ls_resp_valid_o,
    output logic      [XLEN-1:0]   ls_resp_rdata_o,

    // external byte memory
    output logic      [ADDR_W-1:0] mem_addr_o,
    output logic                   mem_we_o,
    output logic      [BYTE_W-1:0] mem_wdata_o,
    input  wire logic [BYTE_W-1:0] mem_rdata_i
);

    // fetch to arbiter
    logic              if_req;
    logic [ADDR_W-1:0] if_addr;
    logic              if_gnt;

    // load/store to arbiter
    logic              ls_req;
    logic [ADDR_W-1:0] ls_addr;
    logic              ls_we;
    logic [BYTE_W-1:0] ls_wdata;
    logic              ls_gnt;

    // shared read byte
    logic [BYTE_W-1:0] arb_rdata;

    inst_fetch u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .inst_ready_i  (inst_ready_i),
        .inst_valid_o  (inst_valid_o),
        .inst_pc_o     (inst_pc_o),
        .inst_o        (inst_o),
        .req_o         (if_req),
        .addr_o        (if_addr),
        .gnt_i         (if_gnt),
        .rdata_i       (arb_rdata)
    );

    load_store_unit u_lsu (
        .clk             (clk),
        .reset_i         (reset_i),
        .ls_valid_i      (ls_valid_i),
        .ls_we_i         (ls_we_i),
        .ls_size_i       (ls_size_i),
        .ls_addr_i       (ls_addr_i),
        .ls_wdata_i      (ls_wdata_i),
        .ls_ready_o      (ls_ready_o),
        .ls_resp_valid_o (ls_resp_valid_o),
        .ls_resp_rdata_o (ls_resp_rdata_o),
        .req_o           (ls_req),
        .addr_o          (ls_addr),
        .we_o            (ls_we),
        .wdata_o         (ls_wdata),
        .gnt_i           (ls_gnt),
        .rdata_i         (arb_rdata)
    );

    mem_arbiter u_arb (
        .clk         (clk),
        .reset_i     (reset_i),
        .if_req_i    (if_req),
        .if_addr_i   (if_addr),
        .if_gnt_o    (if_gnt),
        .ls_req_i    (ls_req),
        .ls_addr_i   (ls_addr),
        .ls_we_i     (ls_we),
        .ls_wdata_i  (ls_wdata),
        .ls_gnt_o    (ls_gnt),
        .rdata_o     (arb_rdata),
        .mem_addr_o  (mem_addr_o),
        .mem_we_o    (mem_we_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import mem_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset_i,

    // fetch requester, read only
    input  wire logic              if_req_i,
    input  wire logic [ADDR_W-1:0] if_addr_i,
    output logic                   if_gnt_o,

    // load/store requester
    input  wire logic              ls_req_i,
    input  wire logic [ADDR_W-1:0] ls_addr_i,
    input  wire logic              ls_we_i,
    input  wire logic [BYTE_W-1:0] ls_wdata_i,
    output logic                   ls_gnt_o,

    // read byte back to both requesters
    output logic      [BYTE_W-1:0] rdata_o,

    // external byte memory
    output logic      [ADDR_W-1:0] mem_addr_o,
    output logic                   mem_we_o,
    output logic      [BYTE_W-1:0] mem_wdata_o,
    input  wire logic [BYTE_W-1:0] mem_rdata_i
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_IF,
        OWN_LS
    } owner_e;

    owner_e owner_q;
    owner_e owner_d;

    // idle arbiter favours load/store, an owner keeps the port
    // until it drops req, then one idle cycle follows
    always_comb begin
        if_gnt_o = 1'b0;
        ls_gnt_o = 1'b0;
        case (owner_q)
            OWN_NONE: begin
                ls_gnt_o = ls_req_i;
                if_gnt_o = if_req_i & ~ls_req_i;
            end
            OWN_IF: begin
                if_gnt_o = if_req_i;
            end
            OWN_LS: begin
                ls_gnt_o = ls_req_i;
            end
            default: begin
                if_gnt_o = 1'b0;
                ls_gnt_o = 1'b0;
            end
        endcase
    end

    // whoever holds a grant now owns the next cycle
    assign owner_d = ls_gnt_o ? OWN_LS : (if_gnt_o ? OWN_IF : OWN_NONE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= owner_d;
        end
    end

    // port mux, no write without a load/store grant
    assign mem_addr_o  = ls_gnt_o ? ls_addr_i : if_addr_i;
    assign mem_we_o    = ls_gnt_o & ls_we_i;
    assign mem_wdata_o = ls_gnt_o ? ls_wdata_i : '0;
    assign rdata_o     = mem_rdata_i;

endmodule

`default_nettype wire

// ==== lsu/load_store_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import mem_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset_i,

    // request from the core
    input  wire logic              ls_valid_i,
    input  wire logic              ls_we_i,
    input  wire mem_size_e         ls_size_i,
    input  wire logic [ADDR_W-1:0] ls_addr_i,
    input  wire logic [XLEN-1:0]   ls_wdata_i,
    output logic                   ls_ready_o,

    // response, one pulse per access
    output logic                   ls_resp_valid_o,
    output logic      [XLEN-1:0]   ls_resp_rdata_o,

    // arbiter side
    output logic                   req_o,
    output logic      [ADDR_W-1:0] addr_o,
    output logic                   we_o,
    output logic      [BYTE_W-1:0] wdata_o,
    input  wire logic              gnt_i,
    input  wire logic [BYTE_W-1:0] rdata_i
);

    typedef enum logic [1:0] {
        LS_IDLE,
        LS_ACCESS,
        LS_FINISH
    } ls_state_e;

    ls_state_e         state_q;
    logic [STEP_W-1:0] step_q;
    logic              got_q;
    logic [STEP_W-1:0] cap_idx;
    logic              last_step;
    logic              store_done;

    // latched request
    logic              we_q;
    logic [ADDR_W-1:0] addr_q;
    logic [XLEN-1:0]   wdata_q;
    logic [STEP_W-1:0] last_q;

    // load bytes collected so far, upper bytes stay zero
    logic [XLEN-1:0]   data_q;
    logic [XLEN-1:0]   load_word;

    assign cap_idx   = step_q - STEP_W'(1);
    assign last_step = (step_q == last_q);

    assign ls_ready_o = (state_q == LS_IDLE);
    assign req_o      = (state_q == LS_ACCESS);
    assign addr_o     = addr_q + ADDR_W'(step_q);
    assign we_o       = (state_q == LS_ACCESS) & we_q;
    // lsb first
    assign wdata_o    = wdata_q[step_q * BYTE_W +: BYTE_W];

    // a store is done on its last granted write
    assign store_done = (state_q == LS_ACCESS) & we_q & gnt_i & last_step;

    // the last load byte is on rdata_i in the finish cycle
    always_comb begin
        load_word = data_q;
        load_word[last_q * BYTE_W +: BYTE_W] = rdata_i;
    end

    assign ls_resp_valid_o = (state_q == LS_FINISH) | store_done;
    assign ls_resp_rdata_o = (state_q == LS_FINISH) ? load_word : '0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= LS_IDLE;
            step_q  <= '0;
            got_q   <= 1'b0;
        end else begin
            got_q <= req_o & gnt_i;

            case (state_q)
                LS_IDLE: begin
                    if (ls_valid_i) begin
                        state_q <= LS_ACCESS;
                        step_q  <= '0;
                    end
                end
                LS_ACCESS: begin
                    if (gnt_i) begin
                        step_q <= step_q + STEP_W'(1);
                        // loads need one more cycle for the last byte
                        if (last_step) begin
                            state_q <= we_q ? LS_IDLE : LS_FINISH;
                        end
                    end
                end
                LS_FINISH: begin
                    state_q <= LS_IDLE;
                end
                default: begin
                    state_q <= LS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ls_ready_o && ls_valid_i) begin
            we_q    <= ls_we_i;
            addr_q  <= ls_addr_i;
            wdata_q <= ls_wdata_i;
            last_q  <= size_last_idx(ls_size_i);
            data_q  <= '0;
        end else if (state_q == LS_ACCESS && got_q && !we_q) begin
            data_q[cap_idx * BYTE_W +: BYTE_W] <= rdata_i;
        end
    end

endmodule

`default_nettype wire

// ==== fetch/inst_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_fetch import mem_pkg::*; (
    input  wire logic              clk,
    input  wire logic              reset_i,

    // branch redirect
    input  wire logic              redirect_i,
    input  wire logic [ADDR_W-1:0] redirect_pc_i,

    // instruction stream
    input  wire logic              inst_ready_i,
    output logic                   inst_valid_o,
    output logic      [ADDR_W-1:0] inst_pc_o,
    output logic      [XLEN-1:0]   inst_o,

    // arbiter side
    output logic                   req_o,
    output logic      [ADDR_W-1:0] addr_o,
    input  wire logic              gnt_i,
    input  wire logic [BYTE_W-1:0] rdata_i
);

    typedef enum logic [1:0] {
        IF_IDLE,
        IF_FETCH,
        IF_LAST,
        IF_HOLD
    } if_state_e;

    if_state_e         state_q;
    logic [STEP_W-1:0] step_q;
    logic [ADDR_W-1:0] pc_q;
    logic              got_q;
    logic [STEP_W-1:0] cap_idx;

    // bytes 0 to 2 of the word, byte 3 comes straight from rdata_i
    logic [BYTE_W-1:0] byte_q [0:WORD_BYTES-2];
    logic [XLEN-1:0]   inst_q;

    // the byte on rdata_i belongs to the step granted last cycle
    assign cap_idx = step_q - STEP_W'(1);

    assign req_o        = (state_q == IF_FETCH);
    assign addr_o       = pc_q + ADDR_W'(step_q);
    assign inst_valid_o = (state_q == IF_HOLD);
    assign inst_pc_o    = pc_q;
    assign inst_o       = inst_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IF_IDLE;
            step_q  <= '0;
            pc_q    <= RESET_PC;
            got_q   <= 1'b0;
        end else begin
            // a redirect throws away the byte in flight
            got_q <= req_o & gnt_i & ~redirect_i;

            if (redirect_i) begin
                state_q <= IF_FETCH;
                step_q  <= '0;
                pc_q    <= redirect_pc_i;
            end else begin
                case (state_q)
                    IF_IDLE: begin
                        state_q <= IF_FETCH;
                    end
                    IF_FETCH: begin
                        // step only moves on a granted address cycle
                        if (gnt_i) begin
                            step_q <= step_q + STEP_W'(1);
                            if (step_q == STEP_W'(WORD_BYTES - 1)) begin
                                state_q <= IF_LAST;
                            end
                        end
                    end
                    IF_LAST: begin
                        state_q <= IF_HOLD;
                    end
                    IF_HOLD: begin
                        // next fetch only after the word is taken
                        if (inst_ready_i) begin
                            pc_q    <= pc_q + ADDR_W'(WORD_BYTES);
                            state_q <= IF_FETCH;
                        end
                    end
                    default: begin
                        state_q <= IF_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IF_FETCH && got_q) begin
            byte_q[cap_idx] <= rdata_i;
        end

        // little-endian assembly, last byte arrives now
        if (state_q == IF_LAST) begin
            inst_q <= {rdata_i, byte_q[2], byte_q[1], byte_q[0]};
        end
    end

endmodule

`default_nettype wire

// ==== common/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // byte address width
    localparam int ADDR_W = 32;

    // instruction and data word width
    localparam int XLEN = 32;

    // external memory data port
    localparam int BYTE_W = 8;

    // bytes in one word and the width of a byte index within it
    localparam int WORD_BYTES = XLEN / BYTE_W;
    localparam int STEP_W = $clog2(WORD_BYTES);

    // program counter after reset
    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0000;

    // access size of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // index of the last byte of an access of the given size
    function automatic logic [STEP_W-1:0] size_last_idx(mem_size_e size);
        logic [STEP_W-1:0] idx;
        case (size)
            SIZE_BYTE: idx = STEP_W'(0);
            SIZE_HALF: idx = STEP_W'(1);
            default:   idx = STEP_W'(WORD_BYTES - 1);
        endcase
        return idx;
    endfunction

endpackage

`default_nettype wire
